// File: Makefile
BIN = obj_dir/VtbMips

.PHONY: compile run clean

compile:
	verilator --binary --timing -sv --top-module tbMips -f filelist.f

# The exit status is the one of grep, so a missing pass line fails the target
run: compile
	$(BIN) | tee /dev/stderr | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+sim
verilog/mipsPkg.sv
verilog/mipsDecoder.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/mipsAlu.sv
verilog/dataMem.sv
verilog/mipsCore.sv
sim/tbMips.sv

// File: sim/mipsModel.svh
// Instruction encodings of the MIPS subset
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_J = 6'h02;
localparam logic [5:0] OPC_BEQ = 6'h04;
localparam logic [5:0] OPC_ORI = 6'h0d;
localparam logic [5:0] OPC_LUI = 6'h0f;
localparam logic [5:0] OPC_LW = 6'h23;
localparam logic [5:0] OPC_SW = 6'h2b;
localparam logic [5:0] FUN_ADDU = 6'h21;
localparam logic [5:0] FUN_SUBU = 6'h23;

localparam int PROG_MAX = 256;

// Program flavors
localparam int K_ALU = 0;
localparam int K_LOADUSE = 1;
localparam int K_BRANCH = 2;
localparam int K_ZERO = 3;
localparam int K_MIXED = 4;

typedef struct packed {
	mipsPkg::wordT pc;
	mipsPkg::regIdxT rd;
	mipsPkg::wordT data;
} expCommitT;

typedef struct packed {
	mipsPkg::wordT pc;
	mipsPkg::wordT addr;
	mipsPkg::wordT data;
} expStoreT;

mipsPkg::wordT progMem [PROG_MAX];
int progLen;
mipsPkg::wordT endPc;
expCommitT commitQ [$];
expStoreT storeQ [$];

function automatic mipsPkg::regIdxT randReg(input int lo, input int hi);
	return mipsPkg::regIdxT'(lo + int'($urandom % (hi - lo + 1)));
endfunction

function automatic mipsPkg::wordT aluWord(input int lo, input int hi);
	logic [15:0] imm;
	imm = 16'($urandom);
	case ($urandom % 4)
		0: return {OPC_SPECIAL, randReg(lo, hi), randReg(lo, hi), randReg(lo, hi), 5'd0, FUN_ADDU};
		1: return {OPC_SPECIAL, randReg(lo, hi), randReg(lo, hi), randReg(lo, hi), 5'd0, FUN_SUBU};
		2: return {OPC_ORI, randReg(lo, hi), randReg(lo, hi), imm};
		default: return {OPC_LUI, 5'd0, randReg(lo, hi), imm};
	endcase
endfunction

// Base register 0, one of the first 16 words
function automatic mipsPkg::wordT memWord(input logic [5:0] op, input mipsPkg::regIdxT rt);
	return {op, 5'd0, rt, 8'h00, 6'($urandom % 16), 2'b00};
endfunction

// Forward target somewhere past the delay slot, closing j included
function automatic mipsPkg::wordT branchWord(input int i, input int n);
	int t;
	mipsPkg::wordT target;
	t = i + 2 + int'($urandom % (n - i - 1));
	target = mipsPkg::RESET_PC + mipsPkg::wordT'(4 * t);
	if ($urandom % 3 == 0) return {OPC_J, target[27:2]};
	return {OPC_BEQ, randReg(1, 4), randReg(1, 4), 16'(t - i - 1)};
endfunction

task automatic genProgram(input int kind, input int n);
	logic lastCtl;
	mipsPkg::regIdxT a, b;
	int pick;
	lastCtl = 1'b0;
	a = 5'd1;
	b = 5'd2;
	endPc = mipsPkg::RESET_PC + mipsPkg::wordT'(4 * n);
	for (int i = 0; i < n; i++) begin
		pick = int'($urandom % 8);
		progMem[i] = aluWord(1, 7);
		if (kind == K_ZERO) begin
			progMem[i] = aluWord(0, 3);
		end else if (kind == K_LOADUSE) begin
			// Producer, store, load, then a use of the loaded register
			case (i % 4)
				0: begin
					a = randReg(1, 7);
					b = randReg(1, 7);
					progMem[i] = {OPC_ORI, a, a, 16'($urandom)};
				end
				1: progMem[i] = memWord(OPC_SW, a);
				2: progMem[i] = memWord(OPC_LW, b);
				default: progMem[i] = {OPC_SPECIAL, b, a, randReg(1, 7), 5'd0, FUN_ADDU};
			endcase
		end else if (kind == K_BRANCH || kind == K_MIXED) begin
			// No branch in a delay slot, no slot on the closing j
			if (!lastCtl && i <= n - 3 && pick >= 6) progMem[i] = branchWord(i, n);
			else if (kind == K_MIXED && pick == 4) progMem[i] = memWord(OPC_LW, randReg(0, 7));
			else if (kind == K_MIXED && pick == 5) progMem[i] = memWord(OPC_SW, randReg(0, 7));
			else if (kind == K_BRANCH) progMem[i] = aluWord(1, 4);
		end
		lastCtl = (progMem[i][31:26] == OPC_BEQ || progMem[i][31:26] == OPC_J);
	end
	progMem[n] = {OPC_J, endPc[27:2]};
	progLen = n + 1;
endtask

////////////////////
// Architectural reference with one delay slot
task automatic runModel();
	mipsPkg::wordT regs [32];
	mipsPkg::wordT mem [64];
	mipsPkg::wordT pc, npc, nnpc, w, a, b, addr, v;
	mipsPkg::regIdxT dest;
	logic [15:0] imm;
	logic wr;
	commitQ.delete();
	storeQ.delete();
	for (int k = 0; k < 32; k++) regs[k] = '0;
	for (int k = 0; k < 64; k++) mem[k] = '0;
	pc = mipsPkg::RESET_PC;
	npc = pc + 32'd4;
	while (pc != endPc) begin
		w = progMem[int'((pc - mipsPkg::RESET_PC) >> 2)];
		imm = w[15:0];
		a = regs[w[25:21]];
		b = regs[w[20:16]];
		addr = a + {{16{imm[15]}}, imm};
		nnpc = npc + 32'd4;
		wr = 1'b0;
		dest = w[20:16];
		v = '0;
		case (w[31:26])
			OPC_SPECIAL: begin
				wr = 1'b1;
				dest = w[15:11];
				v = (w[5:0] == FUN_SUBU) ? a - b : a + b;
			end
			OPC_ORI: begin
				wr = 1'b1;
				v = a | {16'h0000, imm};
			end
			OPC_LUI: begin
				wr = 1'b1;
				v = {imm, 16'h0000};
			end
			OPC_LW: begin
				wr = 1'b1;
				v = mem[addr[7:2]];
			end
			OPC_SW: begin
				mem[addr[7:2]] = b;
				storeQ.push_back('{pc, addr, b});
			end
			OPC_BEQ: if (a == b) nnpc = npc + {{14{imm[15]}}, imm, 2'b00};
			OPC_J: nnpc = {npc[31:28], w[25:0], 2'b00};
			default: ;
		endcase
		// Register 0 never changes and never commits
		if (wr && dest != '0) begin
			regs[dest] = v;
			commitQ.push_back('{pc, dest, v});
		end
		pc = npc;
		npc = nnpc;
	end
endtask

// File: sim/tbMips.sv
`timescale 1ns/1ns

module tbMips;

	localparam int N_ALU = 64;
	localparam int N_LOAD = 48;
	localparam int N_BRANCH = 64;
	localparam int N_ZERO = 32;
	localparam int N_RESET = 16;
	localparam int N_MIXED = 128;
	// Closing j of each of the six programs counts too
	localparam int TOTAL_INSTR = N_ALU + N_LOAD + N_BRANCH + N_ZERO + N_RESET + N_MIXED + 6;
	localparam int CYCLE_LIMIT = 4 * TOTAL_INSTR + 100;

	logic clk;
	logic arstN;
	mipsPkg::wordT instrAddr, instr;
	logic commitValid, storeValid;
	mipsPkg::wordT commitPc, commitData, storePc, storeAddr, storeData;
	mipsPkg::regIdxT commitReg;

	string testName;
	int errors, passCount, failCount, cycles, sinceReset, fetchIdx;

	`include "mipsModel.svh"

	mipsCore #(.DATA_WORDS(64)) u_dut (
		.clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
		.commitValid(commitValid), .commitPc(commitPc), .commitReg(commitReg),
		.commitData(commitData), .storeValid(storeValid), .storePc(storePc),
		.storeAddr(storeAddr), .storeData(storeData)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Past the program end every address holds a j to itself
	always_comb begin
		fetchIdx = int'((instrAddr - mipsPkg::RESET_PC) >> 2);
		if (instrAddr >= mipsPkg::RESET_PC && fetchIdx < progLen) instr = progMem[fetchIdx];
		else instr = {OPC_J, instrAddr[27:2]};
	end

	task automatic reportFault(input string msg);
		errors++;
		$display("%s: %s", testName, msg);
	endtask

	task automatic checkCommit(input mipsPkg::wordT pc, input mipsPkg::regIdxT r,
			input mipsPkg::wordT d);
		expCommitT e;
		e = commitQ.pop_front();
		if (pc !== e.pc || r !== e.rd || d !== e.data) begin
			errors++;
			$display("ERROR %s: commit expected pc %h r%0d=%h, actual pc %h r%0d=%h",
				testName, e.pc, e.rd, e.data, pc, r, d);
		end
	endtask

	task automatic checkStore(input mipsPkg::wordT pc, input mipsPkg::wordT addr,
			input mipsPkg::wordT d);
		expStoreT e;
		e = storeQ.pop_front();
		if (pc !== e.pc || addr !== e.addr || d !== e.data) begin
			errors++;
			$display("ERROR %s: store expected pc %h [%h]=%h, actual pc %h [%h]=%h",
				testName, e.pc, e.addr, e.data, pc, addr, d);
		end
	endtask

	task automatic checkFetchAddr(input mipsPkg::wordT expected, input mipsPkg::wordT actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: first fetch expected %h actual %h", testName, expected, actual);
		end
	endtask

	////////////////////
	// Output monitor sampled away from the rising edge
	always @(negedge clk) begin
		if (!arstN) begin
			if (commitValid || storeValid) reportFault("commit or store strobe high in reset");
			sinceReset = 0;
		end else begin
			if (sinceReset == 0) checkFetchAddr(mipsPkg::RESET_PC, instrAddr);
			if ((commitValid || storeValid) && sinceReset < 4)
				reportFault("a write came out before the first instruction reached write-back");
			if (commitValid) begin
				if (commitQ.size() == 0) reportFault($sformatf("extra commit from pc %h", commitPc));
				else checkCommit(commitPc, commitReg, commitData);
			end
			if (storeValid) begin
				if (storeQ.size() == 0) reportFault($sformatf("extra store from pc %h", storePc));
				else checkStore(storePc, storeAddr, storeData);
			end
			sinceReset++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic runTest(input string name, input int kind, input int n);
		int errBefore;
		testName = name;
		errBefore = errors;
		@(posedge clk);
		arstN <= 1'b0;
		@(negedge clk);
		genProgram(kind, n);
		runModel();
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		do @(negedge clk); while (instrAddr != endPc);
		// Let everything older than the closing j drain through write-back
		repeat (6) @(negedge clk);
		if (commitQ.size() != 0 || storeQ.size() != 0)
			reportFault($sformatf("%0d commits and %0d stores never arrived",
				commitQ.size(), storeQ.size()));
		if (errors == errBefore) begin
			passCount++;
			$display("%s: ok, %0d instructions", name, n);
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errors - errBefore);
		end
	endtask

	initial begin
		arstN = 1'b0;
		errors = 0;
		passCount = 0;
		failCount = 0;
		cycles = 0;
		sinceReset = 0;
		progLen = 0;
		void'($urandom(32'h7828));
		runTest("aluChain", K_ALU, N_ALU);
		runTest("loadUse", K_LOADUSE, N_LOAD);
		runTest("branchSlot", K_BRANCH, N_BRANCH);
		runTest("zeroReg", K_ZERO, N_ZERO);
		runTest("resetState", K_ALU, N_RESET);
		runTest("mixedRandom", K_MIXED, N_MIXED);
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/dataMem.sv
`timescale 1ns/1ns

module dataMem #(
	parameter int DATA_WORDS = 64
) (
	input logic clk,
	input logic arstN,
	input logic writeEn,
	input mipsPkg::wordT addr,
	input mipsPkg::wordT writeData,
	output mipsPkg::wordT readData
);

	localparam int IDX_W = (DATA_WORDS > 1) ? $clog2(DATA_WORDS) : 1;

	mipsPkg::wordT mem [DATA_WORDS];
	logic [IDX_W-1:0] idx;

	// Word address wraps around the array
	assign idx = IDX_W'((addr >> 2) % DATA_WORDS);
	assign readData = mem[idx];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < DATA_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEn) begin
			mem[idx] <= writeData;
		end
	end

	aWriteAligned: assert property (@(posedge clk) disable iff (!arstN)
		writeEn |-> addr[1:0] == 2'b00);

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	input mipsPkg::regIdxT decodeRs,
	input mipsPkg::regIdxT decodeRt,
	input mipsPkg::ctrlT decodeCtrl,
	input mipsPkg::stageT executeStage,
	input mipsPkg::stageT memStage,
	input mipsPkg::stageT writeStage,
	output logic stall,
	output mipsPkg::fwdSelT decodeRsSel,
	output mipsPkg::fwdSelT decodeRtSel,
	output mipsPkg::fwdSelT executeRsSel,
	output mipsPkg::fwdSelT executeRtSel,
	output logic memRtFwd
);

	function automatic logic hits(input mipsPkg::stageT s, input mipsPkg::regIdxT r);
		return s.valid && s.ctrl.regWrite && (s.ctrl.destReg == r);
	endfunction

	// Remaining new time once a producer has moved n stages past execute
	function automatic mipsPkg::timeT ageBy(input mipsPkg::timeT t, input mipsPkg::timeT n);
		return (t > n) ? mipsPkg::timeT'(t - n) : '0;
	endfunction

	// Youngest match wins, and only if its result is ready
	function automatic mipsPkg::fwdSelT pick(input logic hitE, input logic hitM,
			input logic hitW, input mipsPkg::timeT newE, input mipsPkg::timeT newM,
			input mipsPkg::timeT newW);
		mipsPkg::fwdSelT sel;
		sel = mipsPkg::FWD_REG;
		if (hitE) begin
			if (newE == '0) sel = mipsPkg::FWD_EXE;
		end else if (hitM) begin
			if (newM == '0) sel = mipsPkg::FWD_MEM;
		end else if (hitW) begin
			if (newW == '0) sel = mipsPkg::FWD_WB;
		end
		return sel;
	endfunction

	mipsPkg::timeT newE, newM, newW;
	logic dRsE, dRsM, dRsW, dRtE, dRtM, dRtW;
	logic eRsM, eRsW, eRtM, eRtW;
	logic stallE, stallM;

	assign newE = executeStage.ctrl.tNew;
	assign newM = ageBy(memStage.ctrl.tNew, 2'd1);
	assign newW = ageBy(writeStage.ctrl.tNew, 2'd2);

	assign dRsE = hits(executeStage, decodeRs);
	assign dRsM = hits(memStage, decodeRs);
	assign dRsW = hits(writeStage, decodeRs);
	assign dRtE = hits(executeStage, decodeRt);
	assign dRtM = hits(memStage, decodeRt);
	assign dRtW = hits(writeStage, decodeRt);
	assign eRsM = hits(memStage, executeStage.instr[25:21]);
	assign eRsW = hits(writeStage, executeStage.instr[25:21]);
	assign eRtM = hits(memStage, executeStage.instr[20:16]);
	assign eRtW = hits(writeStage, executeStage.instr[20:16]);

	////////////////////
	// Stall when a source is needed before its producer has it
	assign stallE = (dRsE && decodeCtrl.tUseRs < newE) || (dRtE && decodeCtrl.tUseRt < newE);
	assign stallM = (dRsM && !dRsE && decodeCtrl.tUseRs < newM)
		|| (dRtM && !dRtE && decodeCtrl.tUseRt < newM);
	assign stall = stallE || stallM;

	assign decodeRsSel = pick(dRsE, dRsM, dRsW, newE, newM, newW);
	assign decodeRtSel = pick(dRtE, dRtM, dRtW, newE, newM, newW);
	assign executeRsSel = pick(1'b0, eRsM, eRsW, '0, newM, newW);
	assign executeRtSel = pick(1'b0, eRtM, eRtW, '0, newM, newW);

	// Late store data, load in write-back feeding sw in memory
	assign memRtFwd = memStage.valid && memStage.ctrl.memWrite
		&& hits(writeStage, memStage.instr[20:16]);

	always_comb begin
		assert (!(executeStage.valid && executeStage.ctrl.memToReg
			&& executeStage.ctrl.destReg == '0 && stallE))
			else $error("hazardUnit: stall caused by a load to register 0");
	end

endmodule

// File: verilog/mipsAlu.sv
`timescale 1ns/1ns

module mipsAlu (
	input mipsPkg::aluOpT op,
	input mipsPkg::wordT a,
	input mipsPkg::wordT b,
	output mipsPkg::wordT y
);

	always_comb begin
		case (op)
			mipsPkg::ALU_ADD: y = a + b;
			mipsPkg::ALU_SUB: y = a - b;
			mipsPkg::ALU_OR: y = a | b;
			// lui loads the immediate into the upper half
			mipsPkg::ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/1ns

module mipsCore #(
	parameter int DATA_WORDS = 64
) (
	input logic clk,
	input logic arstN,
	output mipsPkg::wordT instrAddr,
	input mipsPkg::wordT instr,
	output logic commitValid,
	output mipsPkg::wordT commitPc,
	output mipsPkg::regIdxT commitReg,
	output mipsPkg::wordT commitData,
	output logic storeValid,
	output mipsPkg::wordT storePc,
	output mipsPkg::wordT storeAddr,
	output mipsPkg::wordT storeData
);

	function automatic mipsPkg::wordT fwdMux(input mipsPkg::fwdSelT sel,
			input mipsPkg::wordT regVal, input mipsPkg::wordT exeVal,
			input mipsPkg::wordT memVal, input mipsPkg::wordT wbVal);
		case (sel)
			mipsPkg::FWD_EXE: return exeVal;
			mipsPkg::FWD_MEM: return memVal;
			mipsPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	mipsPkg::wordT pc, nextPc, slotPc;
	mipsPkg::stageT fetchStage, decodeStage, executeStage, memStage, writeStage;
	mipsPkg::ctrlT decodeCtrl;
	mipsPkg::wordT rfA, rfB, decodeRsVal, decodeRtVal, branchOffset;
	mipsPkg::wordT exeA, exeB, exeImm, aluB, aluY, memRead, memValue;
	mipsPkg::fwdSelT decodeRsSel, decodeRtSel, executeRsSel, executeRtSel;
	logic stall, memRtFwd;

	////////////////////
	// Fetch
	assign instrAddr = pc;

	always_comb begin
		fetchStage = '0;
		fetchStage.valid = 1'b1;
		fetchStage.pc = pc;
		fetchStage.instr = instr;
	end

	////////////////////
	// Decode
	mipsDecoder u_decoder (.instr(decodeStage.instr), .ctrl(decodeCtrl));

	regFile u_regFile (
		.clk(clk), .arstN(arstN),
		.readA(decodeStage.instr[25:21]), .readB(decodeStage.instr[20:16]),
		.dataA(rfA), .dataB(rfB),
		.writeEn(commitValid), .writeIdx(writeStage.ctrl.destReg),
		.writeData(writeStage.result)
	);

	hazardUnit u_hazard (
		.decodeRs(decodeStage.instr[25:21]), .decodeRt(decodeStage.instr[20:16]),
		.decodeCtrl(decodeCtrl), .executeStage(executeStage),
		.memStage(memStage), .writeStage(writeStage),
		.stall(stall),
		.decodeRsSel(decodeRsSel), .decodeRtSel(decodeRtSel),
		.executeRsSel(executeRsSel), .executeRtSel(executeRtSel),
		.memRtFwd(memRtFwd)
	);

	assign decodeRsVal = fwdMux(decodeRsSel, rfA, aluY, memStage.result, writeStage.result);
	assign decodeRtVal = fwdMux(decodeRtSel, rfB, aluY, memStage.result, writeStage.result);

	// Targets are relative to the delay slot
	assign slotPc = decodeStage.pc + 32'd4;
	assign branchOffset = {{14{decodeStage.instr[15]}}, decodeStage.instr[15:0], 2'b00};

	always_comb begin
		nextPc = pc + 32'd4;
		if (decodeStage.valid && decodeCtrl.isJump) begin
			nextPc = {slotPc[31:28], decodeStage.instr[25:0], 2'b00};
		end else if (decodeStage.valid && decodeCtrl.isBranch && decodeRsVal == decodeRtVal) begin
			nextPc = slotPc + branchOffset;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= mipsPkg::RESET_PC;
			decodeStage <= '0;
		end else if (!stall) begin
			pc <= nextPc;
			decodeStage <= fetchStage;
		end
	end

	////////////////////
	// Execute
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			executeStage <= '0;
		end else if (stall) begin
			executeStage <= '0;
		end else begin
			executeStage <= '{valid: decodeStage.valid, pc: decodeStage.pc,
				instr: decodeStage.instr, ctrl: decodeCtrl, rsVal: decodeRsVal,
				rtVal: decodeRtVal, result: '0};
		end
	end

	// Only older stages can feed execute
	assign exeA = (executeRsSel == mipsPkg::FWD_MEM) ? memStage.result
		: (executeRsSel == mipsPkg::FWD_WB) ? writeStage.result : executeStage.rsVal;
	assign exeB = (executeRtSel == mipsPkg::FWD_MEM) ? memStage.result
		: (executeRtSel == mipsPkg::FWD_WB) ? writeStage.result : executeStage.rtVal;

	// Sign extension for addresses and zero extension for ori and lui
	assign exeImm = (executeStage.ctrl.aluOp == mipsPkg::ALU_ADD)
		? {{16{executeStage.instr[15]}}, executeStage.instr[15:0]}
		: {16'h0000, executeStage.instr[15:0]};
	assign aluB = executeStage.ctrl.useImm ? exeImm : exeB;

	mipsAlu u_alu (.op(executeStage.ctrl.aluOp), .a(exeA), .b(aluB), .y(aluY));

	////////////////////
	// Memory
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memStage <= '0;
		end else begin
			memStage <= '{valid: executeStage.valid, pc: executeStage.pc,
				instr: executeStage.instr, ctrl: executeStage.ctrl, rsVal: exeA,
				rtVal: exeB, result: aluY};
		end
	end

	assign storeValid = memStage.valid && memStage.ctrl.memWrite;
	assign storePc = memStage.pc;
	assign storeAddr = memStage.result;
	assign storeData = memRtFwd ? writeStage.result : memStage.rtVal;

	dataMem #(.DATA_WORDS(DATA_WORDS)) u_dataMem (
		.clk(clk), .arstN(arstN),
		.writeEn(storeValid), .addr(memStage.result),
		.writeData(storeData), .readData(memRead)
	);

	assign memValue = memStage.ctrl.memToReg ? memRead : memStage.result;

	////////////////////
	// Write-back
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			writeStage <= '0;
		end else begin
			writeStage <= '{valid: memStage.valid, pc: memStage.pc, instr: memStage.instr,
				ctrl: memStage.ctrl, rsVal: memStage.rsVal, rtVal: storeData,
				result: memValue};
		end
	end

	assign commitValid = writeStage.valid && writeStage.ctrl.regWrite
		&& writeStage.ctrl.destReg != '0;
	assign commitPc = writeStage.pc;
	assign commitReg = writeStage.ctrl.destReg;
	assign commitData = writeStage.result;

endmodule

// File: verilog/mipsDecoder.sv
`timescale 1ns/1ns

module mipsDecoder (
	input mipsPkg::wordT instr,
	output mipsPkg::ctrlT ctrl
);

	mipsPkg::regIdxT rt;
	mipsPkg::regIdxT rd;
	logic [5:0] funct;

	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];

	always_comb begin
		// Default is a no-op that reads nothing
		ctrl = '0;
		ctrl.aluOp = mipsPkg::ALU_ADD;
		ctrl.tUseRs = mipsPkg::T_NEVER;
		ctrl.tUseRt = mipsPkg::T_NEVER;

		case (instr[31:26])
			mipsPkg::OP_SPECIAL: begin
				if (funct == mipsPkg::FN_ADDU || funct == mipsPkg::FN_SUBU) begin
					ctrl.aluOp = (funct == mipsPkg::FN_SUBU) ? mipsPkg::ALU_SUB : mipsPkg::ALU_ADD;
					ctrl.regWrite = 1'b1;
					ctrl.destReg = rd;
					ctrl.tUseRs = 2'd1;
					ctrl.tUseRt = 2'd1;
					ctrl.tNew = 2'd1;
				end
			end
			mipsPkg::OP_ORI, mipsPkg::OP_LUI: begin
				ctrl.aluOp = (instr[31:26] == mipsPkg::OP_LUI) ? mipsPkg::ALU_LUI : mipsPkg::ALU_OR;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				// lui ignores rs entirely
				ctrl.tUseRs = (instr[31:26] == mipsPkg::OP_LUI) ? mipsPkg::T_NEVER : 2'd1;
				ctrl.tNew = 2'd1;
			end
			mipsPkg::OP_LW: begin
				ctrl.useImm = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.tUseRs = 2'd1;
				ctrl.tNew = 2'd2;
			end
			mipsPkg::OP_SW: begin
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.tUseRs = 2'd1;
				// Store data is only needed in memory
				ctrl.tUseRt = 2'd2;
			end
			mipsPkg::OP_BEQ: begin
				ctrl.isBranch = 1'b1;
				ctrl.tUseRs = 2'd0;
				ctrl.tUseRt = 2'd0;
			end
			mipsPkg::OP_J: begin
				ctrl.isJump = 1'b1;
			end
			default: begin
			end
		endcase

		// Writes to register 0 are dropped here
		if (ctrl.destReg == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

endmodule

// File: verilog/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;
	typedef logic [1:0] timeT;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcodeT;

	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23
	} functT;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI} aluOpT;

	// Where an operand comes from
	typedef enum logic [1:0] {FWD_REG, FWD_EXE, FWD_MEM, FWD_WB} fwdSelT;

	// Use time for an operand that is never read
	localparam timeT T_NEVER = 2'd3;

	localparam wordT RESET_PC = 32'h00003000;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		regIdxT destReg;
		logic isBranch;
		logic isJump;
		timeT tUseRs;
		timeT tUseRt;
		timeT tNew;
	} ctrlT;

	typedef struct packed {
		logic valid;
		wordT pc;
		wordT instr;
		ctrlT ctrl;
		wordT rsVal;
		wordT rtVal;
		wordT result;
	} stageT;

endpackage

// File: verilog/regFile.sv
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic arstN,
	input mipsPkg::regIdxT readA,
	input mipsPkg::regIdxT readB,
	output mipsPkg::wordT dataA,
	output mipsPkg::wordT dataB,
	input logic writeEn,
	input mipsPkg::regIdxT writeIdx,
	input mipsPkg::wordT writeData
);

	mipsPkg::wordT regs [1:31];

	// Register 0 reads zero, a same-cycle write is passed through
	function automatic mipsPkg::wordT readPort(input mipsPkg::regIdxT idx);
		if (idx == '0) return '0;
		if (writeEn && writeIdx == idx) return writeData;
		return regs[idx];
	endfunction

	always_comb begin
		dataA = readPort(readA);
		dataB = readPort(readB);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

endmodule
